// File: Bender.yml
package:
  name: dsp_top

sources:
  - files:
      - verilog/dsp_pkg.sv
      - verilog/nco_phase.sv
      - verilog/cordic_rotator.sv
      - verilog/pattern_gen.sv
      - verilog/dac_select.sv
      - verilog/capture_writer.sv
      - verilog/dsp_top.sv
  - target: test
    files:
      - tb/tb_dsp_top.sv

// File: tb/dsp_cases.txt
# kind freq(hex) amp(hex) test_period src cycles tol
# src is a dac or capture source code and tol is in output lsb
phase   00123456 6000 3  1 200  0
phase   7fffffff 6000 3  1 100  0
phase   fffff000 6000 3  1 100  0
square  00000000 6000 5  0 100  0
square  00000000 6000 0  0 40   0
square  00000000 6000 12 0 120  0
ramp    00000000 6000 3  4 300  0
ramp    00000000 6000 3  7 30   0
ramp    00000000 6000 3  5 30   0
cos     04000000 7000 3  2 80   80
sin     04000000 7000 3  3 80   80
cos     00400000 4000 3  2 1100 60
sin     00400000 4000 3  3 1100 60
capture 00400000 4000 3  0 2100 0
capture 00400000 4000 3  1 2100 0

// File: tb/tb_dsp_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_top import dsp_pkg::*; ();

	localparam int settle = cordic_latency + 4;
	localparam int max_cases = 32;
	localparam int slot_n = 4096; // longest tone period in cycles

	logic dspif;
	logic rst_n;
	logic [phase_w-1:0] freq;
	logic [sample_w-1:0] amp;
	logic [period_w-1:0] test_period;
	dac_src_e dac_src;
	cap_src_e cap_src;
	logic capture_restart;
	logic [adc_w-1:0] adc_data;
	logic [dac_w-1:0] dac_data;
	logic [cap_addr_w-1:0] cap_addr;
	logic [cap_we_w-1:0] cap_we;
	logic [adc_w-1:0] cap_data;

	logic [63:0] c_kind [0:max_cases-1];
	logic [31:0] c_freq [0:max_cases-1];
	int c_amp [0:max_cases-1];
	int c_period [0:max_cases-1];
	int c_src [0:max_cases-1];
	int c_cycles [0:max_cases-1];
	int c_tol [0:max_cases-1];
	int n_cases;

	logic [31:0] lfsr = 32'hb740a8f9;
	logic [adc_w-1:0] adc_q [$]; // driven words with the oldest first
	int cyc = 0;
	int cycle_limit = 32'h7fffffff;
	int error_cnt = 0;
	logic signed [sample_w-1:0] cos_slot [0:slot_n-1];
	logic slot_ok [0:slot_n-1];
	logic [phase_w-1:0] cos_freq = '0;

	dsp_top u_dsp_top (.*);

	always #20 dspif = ~dspif;

	always @(posedge dspif) begin
		cyc <= cyc + 1;
		if (cyc >= cycle_limit) begin
			$display("timeout after %0d clock cycles, the cases did not finish", cyc);
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	// ####################################################################
	// reporting and compare tasks

	task automatic report_error(input string msg);
		error_cnt++;
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_dac_word(input logic [dac_w-1:0] got, input logic [dac_w-1:0] exp,
			input string what);
		if (got !== exp)
			report_error($sformatf("%s, dac word %h, expected %h", what, got, exp));
	endtask

	task automatic check_cap_word(input logic [adc_w-1:0] got, input logic [adc_w-1:0] exp,
			input string what);
		if (got !== exp)
			report_error($sformatf("%s, capture word %h, expected %h", what, got, exp));
	endtask

	task automatic check_addr(input logic [cap_addr_w-1:0] got,
			input logic [cap_addr_w-1:0] exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s, cap_addr %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_we(input logic [cap_we_w-1:0] got, input logic [cap_we_w-1:0] exp,
			input string what);
		if (got !== exp)
			report_error($sformatf("%s, cap_we %b, expected %b", what, got, exp));
	endtask

	task automatic check_within(input int got, input int exp, input int tol, input string what);
		if (got > exp + tol || got < exp - tol)
			report_error($sformatf("%s, got %0d, expected %0d +- %0d", what, got, exp, tol));
	endtask

	// galois form with taps of x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
	endfunction

	task automatic drive_adc_word();
		logic [adc_w-1:0] w;
		for (int b = 0; b < adc_w; b++) begin
			lfsr = lfsr_next(lfsr);
			w[b] = lfsr[0];
		end
		adc_data = w;
		adc_q.push_back(w);
	endtask

	task automatic read_cases();
		int fd;
		int r;
		logic [63:0] kind;
		logic [8*200-1:0] rest;
		n_cases = 0;
		fd = $fopen("tb/dsp_cases.txt", "r");
		if (fd == 0)
			abort_run("could not open the case file tb/dsp_cases.txt");
		else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "#") begin
					r = $fgets(rest, fd);
				end else begin
					c_kind[n_cases] = kind;
					r = $fscanf(fd, "%h %h %d %d %d %d", c_freq[n_cases], c_amp[n_cases],
						c_period[n_cases], c_src[n_cases], c_cycles[n_cases], c_tol[n_cases]);
					if (r != 6 || n_cases == max_cases - 1)
						abort_run($sformatf("case line %0d is malformed or one too many", n_cases));
					else
						n_cases++;
				end
			end
			$fclose(fd);
		end
	endtask

	// ####################################################################
	// one task per kind of case

	task automatic phase_case(input int k, input string tag);
		logic [sample_w-1:0] prev;
		logic [sample_w-1:0] step;
		logic [sample_w-1:0] d;
		step = c_freq[k][31:16];
		for (int n = 0; n < c_cycles[k]; n++) begin
			check_dac_word(dac_data, {dac_lanes{dac_data[sample_w-1:0]}}, tag);
			d = dac_data[sample_w-1:0] - prev - step; // carry from the low half adds one
			if (n > 0)
				check_within(d, 0, 1, {tag, " phase step"});
			prev = dac_data[sample_w-1:0];
			@(negedge dspif);
		end
	endtask

	task automatic square_case(input int k, input string tag);
		logic [sample_w-1:0] lvl [0:3];
		logic [sample_w-1:0] cur;
		int idx;
		int run_len;
		lvl = '{16'h0000, 16'h7fff, 16'h8000, 16'hffff};
		idx = -1;
		run_len = -1; // first run is partial
		for (int n = 0; n < c_cycles[k]; n++) begin
			cur = dac_data[sample_w-1:0];
			check_dac_word(dac_data, {dac_lanes{cur}}, tag);
			if (idx < 0) begin
				for (int i = 0; i < 4; i++)
					if (lvl[i] == cur)
						idx = i;
				if (idx < 0)
					report_error($sformatf("%s, word %h is not a square level", tag, cur));
			end else if (cur != lvl[idx]) begin
				idx = (idx + 1) % 4;
				check_dac_word(dac_data, {dac_lanes{lvl[idx]}}, {tag, " level order"});
				if (run_len >= 0)
					check_within(run_len, c_period[k] + 1, 0, {tag, " dwell"});
				run_len = 0;
			end
			if (run_len >= 0)
				run_len++;
			@(negedge dspif);
		end
	endtask

	task automatic ramp_case(input int k, input string tag);
		logic [dac_w-1:0] exp;
		logic [ramp_w-1:0] base;
		base = dac_data[sample_w-1 -: ramp_w];
		for (int n = 0; n < c_cycles[k]; n++) begin
			exp = '0; // unused codes
			if (c_src[k] == src_ramp)
				for (int i = 0; i < dac_lanes; i++)
					exp[i*sample_w +: sample_w] = {base, 4'(i)};
			check_dac_word(dac_data, exp, tag);
			base++;
			@(negedge dspif);
		end
	endtask

	// cos and sin runs share one freq so each slot is one phase
	task automatic tone_case(input int k, input string tag);
		logic signed [sample_w-1:0] v;
		logic signed [sample_w-1:0] peak;
		longint per;
		int slot;
		real mag;
		per = (c_freq[k] == 0) ? 0 : 64'h1_0000_0000 / c_freq[k];
		peak = 16'sh8000;
		if (per == 0 || per > slot_n || per * c_freq[k] != 64'h1_0000_0000
				|| (c_kind[k] == "sin" && cos_freq != c_freq[k]))
			abort_run($sformatf("%s needs a freq that divides 2**32 and a cos case before sin",
				tag));
		else begin
			if (c_kind[k] == "cos") begin
				cos_freq = c_freq[k];
				for (int s = 0; s < slot_n; s++)
					slot_ok[s] = 1'b0;
			end
			for (int n = 0; n < c_cycles[k]; n++) begin
				v = dac_data[sample_w-1:0];
				slot = cyc % per;
				check_dac_word(dac_data, {dac_lanes{v}}, tag);
				if (c_kind[k] == "cos") begin
					cos_slot[slot] = v;
					slot_ok[slot] = 1'b1;
					if (v > peak)
						peak = v;
				end else if (slot_ok[slot]) begin
					mag = $sqrt(real'(v) * v + real'(cos_slot[slot]) * cos_slot[slot]);
					check_within($rtoi(mag + 0.5), c_amp[k], c_tol[k], {tag, " magnitude"});
				end
				@(negedge dspif);
			end
			if (c_kind[k] == "cos")
				check_within(peak, c_amp[k], c_tol[k], {tag, " cos peak"});
		end
	endtask

	task automatic capture_case(input int k, input string tag);
		logic [cap_addr_w-1:0] exp_addr;
		logic [adc_w-1:0] exp;
		logic [ctr_w-1:0] base;
		exp_addr = '0;
		base = cap_data[sample_w-1 -: ctr_w];
		adc_q.delete();
		for (int n = 0; n < c_cycles[k]; n++) begin
			check_addr(cap_addr, exp_addr, tag);
			check_we(cap_we, {cap_we_w{~&exp_addr}}, tag);
			if (c_src[k] == cap_count) begin
				for (int j = 0; j < adc_lanes; j++)
					exp[j*sample_w +: sample_w] = {base, 2'(j)};
				check_cap_word(cap_data, exp, tag);
				base++;
			end else if (adc_q.size() > 0)
				check_cap_word(cap_data, adc_q.pop_front(), tag);
			capture_restart = 1'b0;
			drive_adc_word();
			if (exp_addr != '1)
				exp_addr++; // parks on the last entry
			@(negedge dspif);
		end
	endtask

	task automatic run_case(input int k);
		string tag;
		tag = $sformatf("case %0d", k);
		freq = c_freq[k];
		amp = c_amp[k];
		test_period = c_period[k];
		if (c_kind[k] == "capture") begin
			cap_src = cap_src_e'(c_src[k][1:0]);
			capture_restart = 1'b1;
		end else begin
			dac_src = dac_src_e'(c_src[k][2:0]);
		end
		repeat (settle) @(negedge dspif);
		case (c_kind[k])
			"phase": phase_case(k, tag);
			"square": square_case(k, tag);
			"ramp": ramp_case(k, tag);
			"cos", "sin": tone_case(k, tag);
			"capture": capture_case(k, tag);
			default: abort_run($sformatf("%s has a kind that is not known", tag));
		endcase
	endtask

	initial begin
		int total;
		dspif = 1'b0;
		rst_n = 1'b0;
		freq = '0;
		amp = '0;
		test_period = '0;
		dac_src = src_square;
		cap_src = cap_adc;
		capture_restart = 1'b0;
		adc_data = '0;
		read_cases();
		total = 0;
		for (int k = 0; k < n_cases; k++)
			total += c_cycles[k] + settle + 8;
		cycle_limit = total + 2048 + 200;
		repeat (8) @(negedge dspif);
		check_dac_word(dac_data, '0, "reset");
		check_cap_word(cap_data, '0, "reset");
		check_addr(cap_addr, '0, "reset");
		check_we(cap_we, '1, "reset");
		rst_n = 1'b1;
		for (int k = 0; k < n_cases; k++)
			run_case(k);
		if (error_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
verilog/dsp_pkg.sv
verilog/nco_phase.sv
verilog/cordic_rotator.sv
verilog/pattern_gen.sv
verilog/dac_select.sv
verilog/capture_writer.sv
verilog/dsp_top.sv
tb/tb_dsp_top.sv

// File: verilog/capture_writer.sv
`timescale 1ns/1ps
`default_nettype none

module capture_writer import dsp_pkg::*; (
	input  wire logic                        dspif,
	input  wire logic                        rst_n,
	input  wire logic                        capture_restart,
	input  wire cap_src_e                    cap_src,
	input  wire logic        [adc_w-1:0]     adc_data,
	input  wire logic        [adc_w-1:0]     count_word,
	input  wire logic signed [sample_w-1:0]  cos,
	input  wire logic signed [sample_w-1:0]  sin,
	output logic             [cap_addr_w-1:0] cap_addr,
	output logic             [cap_we_w-1:0]  cap_we,
	output logic             [adc_w-1:0]     cap_data
);

	logic at_last;

	assign at_last = &cap_addr;

	// address runs up once and parks on the last entry
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			cap_addr <= '0;
		end else if (capture_restart) begin
			cap_addr <= '0;
		end else if (!at_last) begin
			cap_addr <= cap_addr + 1'b1;
		end
	end

	assign cap_we = {cap_we_w{~at_last}}; // stop writing once parked

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			cap_data <= '0;
		end else begin
			case (cap_src)
				cap_adc:   cap_data <= adc_data;
				cap_count: cap_data <= count_word;
				cap_cos:   cap_data <= {adc_lanes{cos}};
				default:   cap_data <= {adc_lanes{sin}};
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/cordic_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_rotator import dsp_pkg::*; (
	input  wire logic                        dspif,
	input  wire logic                        rst_n,
	input  wire logic        [sample_w-1:0]  amp,
	input  wire logic  [cordic_phase_w-1:0]  phase,
	output logic signed      [sample_w-1:0]  cos,
	output logic signed      [sample_w-1:0]  sin
);

	logic [2*sample_w-1:0] amp_prod;
	logic signed [cordic_w-1:0] amp_scaled;
	logic [1:0] quadrant;
	logic signed [cordic_z_w-1:0] z_start;

	// index 0 of the pipeline is the input register
	logic signed [cordic_w-1:0] xp [0:cordic_stages];
	logic signed [cordic_w-1:0] yp [0:cordic_stages];
	logic signed [cordic_z_w-1:0] zp [0:cordic_stages-1];

	function automatic logic signed [sample_w-1:0] round_sat(
		input logic signed [cordic_w-1:0] v
	);
		logic signed [cordic_w-1:0] r;
		r = (v + cordic_w'(1 << (cordic_frac - 1))) >>> cordic_frac;
		if (r > (2 ** (sample_w - 1)) - 1) begin
			return {1'b0, {(sample_w-1){1'b1}}};
		end else if (r < -(2 ** (sample_w - 1))) begin
			return {1'b1, {(sample_w-1){1'b0}}};
		end
		return r[sample_w-1:0];
	endfunction

	// ####################################################################
	// input stage

	// pre-scale so the cordic gain brings the result back to amp
	assign amp_prod = amp * cordic_gain_inv;
	assign amp_scaled = cordic_w'(amp_prod[2*sample_w-1:sample_w-cordic_frac]);

	assign quadrant = phase[cordic_phase_w-1 -: 2];
	assign z_start = {2'b00, phase[cordic_phase_w-3:0],
		{(cordic_z_w-cordic_phase_w){1'b0}}};

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			xp[0] <= '0;
			yp[0] <= '0;
			zp[0] <= '0;
		end else begin
			case (quadrant) // coarse rotation by multiples of 90 deg
				2'd0: begin
					xp[0] <= amp_scaled;
					yp[0] <= '0;
				end
				2'd1: begin
					xp[0] <= '0;
					yp[0] <= amp_scaled;
				end
				2'd2: begin
					xp[0] <= -amp_scaled;
					yp[0] <= '0;
				end
				default: begin
					xp[0] <= '0;
					yp[0] <= -amp_scaled;
				end
			endcase
			zp[0] <= z_start; // residual in [0, 90 deg)
		end
	end

	// ####################################################################
	// micro-rotations

	for (genvar k = 0; k < cordic_stages; k++) begin : g_stage
		logic cw;

		assign cw = zp[k][cordic_z_w-1]; // turn back on a negative residual

		always_ff @(posedge dspif) begin
			if (!rst_n) begin
				xp[k+1] <= '0;
				yp[k+1] <= '0;
			end else if (cw) begin
				xp[k+1] <= xp[k] + (yp[k] >>> k);
				yp[k+1] <= yp[k] - (xp[k] >>> k);
			end else begin
				xp[k+1] <= xp[k] - (yp[k] >>> k);
				yp[k+1] <= yp[k] + (xp[k] >>> k);
			end
		end

		// the last stage has no further use for the angle
		if (k < cordic_stages - 1) begin : g_angle
			always_ff @(posedge dspif) begin
				if (!rst_n) begin
					zp[k+1] <= '0;
				end else if (cw) begin
					zp[k+1] <= zp[k] + cordic_atan[k];
				end else begin
					zp[k+1] <= zp[k] - cordic_atan[k];
				end
			end
		end
	end

	// ####################################################################
	// output register

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			cos <= '0;
			sin <= '0;
		end else begin
			cos <= round_sat(xp[cordic_stages]);
			sin <= round_sat(yp[cordic_stages]);
		end
	end

endmodule

`default_nettype wire

// File: verilog/dac_select.sv
`timescale 1ns/1ps
`default_nettype none

module dac_select import dsp_pkg::*; (
	input  wire logic                        dspif,
	input  wire logic                        rst_n,
	input  wire dac_src_e                    dac_src,
	input  wire logic  [cordic_phase_w-1:0]  phase,
	input  wire logic signed [sample_w-1:0]  cos,
	input  wire logic signed [sample_w-1:0]  sin,
	input  wire logic        [sample_w-1:0]  square_word,
	input  wire logic        [dac_w-1:0]     ramp_word,
	output logic             [dac_w-1:0]     dac_data
);

	logic [dac_w-1:0] sel_word;

	// source mux replicating one sample across all lanes
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			sel_word <= '0;
		end else begin
			case (dac_src)
				src_square: sel_word <= {dac_lanes{square_word}};
				src_phase:  sel_word <= {dac_lanes{phase[cordic_phase_w-1:1]}};
				src_cos:    sel_word <= {dac_lanes{cos}};
				src_sin:    sel_word <= {dac_lanes{sin}};
				src_ramp:   sel_word <= ramp_word;
				default:    sel_word <= '0; // unused codes
			endcase
		end
	end

	// output register toward the converter lanes
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			dac_data <= '0;
		end else begin
			dac_data <= sel_word;
		end
	end

endmodule

`default_nettype wire

// File: verilog/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	// ####################################################################
	// widths
	localparam int sample_w = 16;
	localparam int dac_lanes = 16;
	localparam int dac_w = sample_w * dac_lanes;
	localparam int adc_lanes = 4;
	localparam int adc_w = sample_w * adc_lanes;
	localparam int cap_we_w = adc_w / 8; // one enable per byte
	localparam int cap_addr_w = 11;
	localparam int period_w = 32;
	localparam int ramp_w = 12;
	localparam int ctr_w = 14;

	// ####################################################################
	// nco and cordic
	localparam int phase_w = 32;
	localparam int cordic_phase_w = 17; // top of the accumulator
	localparam int cordic_stages = 16;
	localparam int cordic_latency = 18; // input reg + stages + output reg
	localparam int cordic_w = 22; // growth and guard bits
	localparam int cordic_frac = 4;
	localparam int cordic_z_w = cordic_phase_w + 3; // full circle is 2**cordic_z_w

	localparam logic [sample_w-1:0] cordic_gain_inv = 16'h9b75; // 1/1.64676 in q0.16

	// atan(2**-i) in the same angle units as the residual
	localparam logic signed [cordic_z_w-1:0] cordic_atan [0:cordic_stages-1] = '{
		20'sd131072, 20'sd77376, 20'sd40884, 20'sd20753,
		20'sd10417,  20'sd5213,  20'sd2607,  20'sd1304,
		20'sd652,    20'sd326,   20'sd163,   20'sd81,
		20'sd41,     20'sd20,    20'sd10,    20'sd5
	};

	typedef enum logic [2:0] {
		src_square = 3'd0,
		src_phase  = 3'd1,
		src_cos    = 3'd2,
		src_sin    = 3'd3,
		src_ramp   = 3'd4
	} dac_src_e;

	typedef enum logic [1:0] {
		cap_adc   = 2'd0,
		cap_count = 2'd1,
		cap_cos   = 2'd2,
		cap_sin   = 2'd3
	} cap_src_e;

endpackage

`default_nettype wire

// File: verilog/dsp_top.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_top import dsp_pkg::*; (
	input  wire logic                    dspif,
	input  wire logic                    rst_n,
	input  wire logic [phase_w-1:0]      freq,
	input  wire logic [sample_w-1:0]     amp,
	input  wire logic [period_w-1:0]     test_period,
	input  wire dac_src_e                dac_src,
	input  wire cap_src_e                cap_src,
	input  wire logic                    capture_restart,
	input  wire logic [adc_w-1:0]        adc_data,
	output logic      [dac_w-1:0]        dac_data,
	output logic      [cap_addr_w-1:0]   cap_addr,
	output logic      [cap_we_w-1:0]     cap_we,
	output logic      [adc_w-1:0]        cap_data
);

	logic [cordic_phase_w-1:0] phase;
	logic signed [sample_w-1:0] cos;
	logic signed [sample_w-1:0] sin;
	logic [sample_w-1:0] square_word;
	logic [dac_w-1:0] ramp_word;
	logic [adc_w-1:0] count_word;

	// ####################################################################
	// tone path
	nco_phase u_nco_phase (
		.dspif (dspif),
		.rst_n (rst_n),
		.freq  (freq),
		.phase (phase)
	);

	cordic_rotator u_cordic_rotator (
		.dspif (dspif),
		.rst_n (rst_n),
		.amp   (amp),
		.phase (phase),
		.cos   (cos),
		.sin   (sin)
	);

	// ####################################################################
	// test patterns and sinks
	pattern_gen u_pattern_gen (
		.dspif       (dspif),
		.rst_n       (rst_n),
		.test_period (test_period),
		.square_word (square_word),
		.ramp_word   (ramp_word),
		.count_word  (count_word)
	);

	dac_select u_dac_select (
		.dspif       (dspif),
		.rst_n       (rst_n),
		.dac_src     (dac_src),
		.phase       (phase),
		.cos         (cos),
		.sin         (sin),
		.square_word (square_word),
		.ramp_word   (ramp_word),
		.dac_data    (dac_data)
	);

	capture_writer u_capture_writer (
		.dspif           (dspif),
		.rst_n           (rst_n),
		.capture_restart (capture_restart),
		.cap_src         (cap_src),
		.adc_data        (adc_data),
		.count_word      (count_word),
		.cos             (cos),
		.sin             (sin),
		.cap_addr        (cap_addr),
		.cap_we          (cap_we),
		.cap_data        (cap_data)
	);

endmodule

`default_nettype wire

// File: verilog/nco_phase.sv
`timescale 1ns/1ps
`default_nettype none

module nco_phase import dsp_pkg::*; (
	input  wire logic                      dspif,
	input  wire logic                      rst_n,
	input  wire logic [phase_w-1:0]        freq,
	output logic      [cordic_phase_w-1:0] phase
);

	logic [phase_w-1:0] freq_q;
	logic [phase_w-1:0] acc;

	// freq is a level from the register bus
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			freq_q <= '0;
		end else begin
			freq_q <= freq;
		end
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= acc + freq_q; // wraps mod 2**32
		end
	end

	assign phase = acc[phase_w-1 -: cordic_phase_w];

endmodule

`default_nettype wire

// File: verilog/pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_gen import dsp_pkg::*; (
	input  wire logic                  dspif,
	input  wire logic                  rst_n,
	input  wire logic [period_w-1:0]   test_period,
	output logic      [sample_w-1:0]   square_word,
	output logic      [dac_w-1:0]      ramp_word,
	output logic      [adc_w-1:0]      count_word
);

	logic [period_w-1:0] dwell_cnt;
	logic [1:0] level;
	logic [ramp_w-1:0] ramp_cnt;
	logic [ctr_w-1:0] cap_cnt;

	// four level square wave held test_period+1 cycles per level
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			dwell_cnt <= '0;
			level <= '0;
		end else if (dwell_cnt == '0) begin
			dwell_cnt <= test_period;
			level <= level + 2'd1;
		end else begin
			dwell_cnt <= dwell_cnt - 1'b1;
		end
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			square_word <= '0;
		end else begin
			square_word <= {level[1], {(sample_w-1){level[0]}}};
		end
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			ramp_cnt <= '0;
			cap_cnt <= '0;
		end else begin
			ramp_cnt <= ramp_cnt + 1'b1;
			cap_cnt <= cap_cnt + 1'b1;
		end
	end

	// lane index sits in the low bits of every lane
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			ramp_word <= '0;
			count_word <= '0;
		end else begin
			for (int i = 0; i < dac_lanes; i++) begin
				ramp_word[i*sample_w +: sample_w] <= {ramp_cnt, i[sample_w-ramp_w-1:0]};
			end
			for (int j = 0; j < adc_lanes; j++) begin
				count_word[j*sample_w +: sample_w] <= {cap_cnt, j[sample_w-ctr_w-1:0]};
			end
		end
	end

endmodule

`default_nettype wire
